// File: bench/mem_model.sv
`default_nettype none

`include "cache_fill_config.svh"

module mem_model (
	input wire logic clk,
	input wire logic reset,
	input wire cache_pkg::mem_req_t mem_req, // one read strobe per word from the cache
	output cache_pkg::mem_resp_t mem_resp
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int latency = 3; // read to data in cycles, same value as in tb_cache
	localparam int drive_delay = 5; // responses move a little after the rising edge

	logic [latency-1:0] valid_pipe; // one slot per cycle of latency
	logic [`CACHE_ADDR_W-1:0] addr_pipe [latency];
	cache_pkg::mem_resp_t resp_q = '0;

	// memory contents are a fixed function of the word address
	function automatic logic [`CACHE_WORD_W-1:0] stored_word(input logic [`CACHE_ADDR_W-1:0] addr);
		return {addr[10:0], addr[15:11]} ^ 16'hA5C3; // rotate left by 5, then scramble
	endfunction

	// ******************************
	// read pipeline
	// ******************************

	// a read is accepted every cycle and answered in order after latency cycles
	always @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0; // nothing in flight after reset
		end else begin
			valid_pipe <= {valid_pipe[latency-2:0], mem_req.read};
		end
		addr_pipe[0] <= mem_req.addr;
		for (int i = 1; i < latency; i++)
			addr_pipe[i] <= addr_pipe[i-1]; // address travels with its valid bit
	end

	// the oldest slot is presented once the edge has settled
	always @(posedge clk) begin
		#(drive_delay);
		resp_q.valid = valid_pipe[latency-1];
		resp_q.data = valid_pipe[latency-1] ? stored_word(addr_pipe[latency-1]) : '0;
	end

	assign mem_resp = resp_q;

endmodule

`default_nettype wire

// File: bench/tb_cache.sv
`default_nettype none

`include "cache_fill_config.svh"

module tb_cache;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period = 100;
	localparam int drive_delay = 5;
	localparam int reset_cycles = 8;
	localparam int mem_latency = 3; // same value as the memory model uses
	localparam int block_words = `CACHE_BLOCK_WORDS;
	localparam int fill_stall_cycles = 10 + mem_latency; // miss cycle plus 9 + L busy cycles
	localparam int random_accesses = 200;
	// cold miss, reread of one block, conflict sequence, random run, held request
	localparam int total_accesses = 1 + block_words + 4 + random_accesses + 1;
	localparam int watchdog_cycles = reset_cycles + 16 + total_accesses * (12 + mem_latency);

	logic clk = 1'b0;
	logic reset;
	cache_pkg::cpu_req_t cpu_req;
	cache_pkg::cpu_resp_t cpu_resp;
	cache_pkg::mem_req_t mem_req;
	cache_pkg::mem_resp_t mem_resp;

	int check_count = 0;
	int error_count = 0;
	int failed_tests = 0;
	int miss_count = 0;
	int total_reads = 0; // every mem_read strobe seen after reset
	logic last_was_miss;
	logic [15:0] rng_state = 16'd13;
	logic [`CACHE_TAG_W-1:0] tag_pool [4] = '{7'h05, 7'h09, 7'h31, 7'h6c};

	// shadow of the tag array, updated after each access completes
	logic [`CACHE_TAG_W-1:0] shadow_tag [`CACHE_SETS];
	logic [`CACHE_SETS-1:0] shadow_valid;

	cache_top dut_i (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.cpu_resp(cpu_resp),
		.mem_req(mem_req),
		.mem_resp(mem_resp)
	);

	mem_model mem_i (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_resp(mem_resp)
	);

	always begin
		#(clk_period / 2);
		clk = ~clk;
	end

	// ******************************
	// checking helpers
	// ******************************

	// expected memory word, address rotated left by 5 and scrambled
	function automatic logic [15:0] pattern_word(input logic [15:0] addr);
		logic [15:0] word_addr;
		word_addr = {addr[15:1], 1'b0}; // words are aligned
		return {word_addr[10:0], word_addr[15:11]} ^ 16'hA5C3;
	endfunction

	function automatic logic [15:0] xorshift16(input logic [15:0] x);
		logic [15:0] y;
		y = x ^ (x << 7);
		y = y ^ (y >> 9);
		y = y ^ (y << 8);
		return y;
	endfunction

	task automatic check_word(input string name, input logic [15:0] expected,
		input logic [15:0] observed);
		check_count++;
		assert (observed === expected)
		else begin
			error_count++;
			$display("ERR t=%0t %s expected %h observed %h", $time, name, expected, observed);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic observed);
		check_count++;
		assert (observed === expected)
		else begin
			error_count++;
			$display("ERR t=%0t %s expected %b observed %b", $time, name, expected, observed);
		end
	endtask

	task automatic check_number(input string name, input int expected, input int observed);
		check_count++;
		assert (observed == expected)
		else begin
			error_count++;
			$display("ERR t=%0t %s expected %0d observed %0d", $time, name, expected, observed);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("failure at t=%0t: %s", $time, what);
	endtask

	task automatic finish_test(input int number, input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %0d %s: ok", number, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", number, name, error_count - errors_before);
		end
	endtask

	// quiet cache, no request in flight
	task automatic check_idle();
		@(negedge clk);
		check_bit("mem_req.read", 1'b0, mem_req.read);
		check_bit("cpu_resp.stall", 1'b0, cpu_resp.stall);
		check_bit("cpu_resp.rd_valid", 1'b0, cpu_resp.rd_valid);
	endtask

	// one processor read held until rd_valid, burst checked against the shadow tags
	task automatic do_access(input logic [15:0] addr);
		cache_pkg::cache_addr_t a;
		logic predict_hit;
		logic [15:0] base;
		int stall_cycles;
		int reads;
		a.raw = addr;
		base = {addr[15:4], 4'h0}; // block base, offset cleared
		predict_hit = shadow_valid[a.fields.index] && (shadow_tag[a.fields.index] == a.fields.tag);
		stall_cycles = 0;
		reads = 0;
		@(posedge clk);
		#(drive_delay);
		cpu_req.req = 1'b1;
		cpu_req.addr.raw = addr;
		@(negedge clk);
		while (!cpu_resp.rd_valid && cpu_resp.stall) begin
			if (mem_req.read) begin
				check_number("mem_read cycle", reads + 1, stall_cycles); // back to back from T+1
				check_word("mem_req.addr", base + 16'(2 * reads), mem_req.addr);
				reads++;
			end
			stall_cycles++;
			@(negedge clk);
		end
		if (!cpu_resp.rd_valid)
			report_failure("request neither stalled nor returned data");
		check_word("cpu_resp.rdata", pattern_word(addr), cpu_resp.rdata);
		check_bit("mem_req.read", 1'b0, mem_req.read); // held request must not start a second burst
		check_number("stall cycles", predict_hit ? 0 : fill_stall_cycles, stall_cycles);
		check_number("mem_read strobes", predict_hit ? 0 : block_words, reads);
		if (!predict_hit)
			miss_count++;
		shadow_tag[a.fields.index] = a.fields.tag;
		shadow_valid[a.fields.index] = 1'b1;
		last_was_miss = (stall_cycles != 0); // a miss seen at the cache port as a stalled cycle
	endtask

	// ******************************
	// concurrent checks
	// ******************************

	valid_not_stalled: assert property (@(posedge clk) !(cpu_resp.rd_valid && cpu_resp.stall))
		else report_failure("rd_valid high in a stalled cycle");

	read_only_in_stall: assert property (@(posedge clk) disable iff (reset)
		mem_req.read |-> cpu_resp.stall)
		else report_failure("mem_read strobe while the processor was not stalled");

	always @(negedge clk) begin
		if (!reset && mem_req.read)
			total_reads++; // compared with eight per predicted miss at the end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: no result after %0d cycles", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	// ******************************
	// test sequence
	// ******************************

	initial begin
		int errors_before;
		logic [15:0] r_addr;
		cpu_req = '0;
		reset = 1'b1;
		shadow_valid = '0; // all sets empty after reset, like the valid bits

		errors_before = error_count;
		repeat (reset_cycles)
			check_idle();
		@(posedge clk);
		#(drive_delay);
		reset = 1'b0;
		repeat (3)
			check_idle();
		finish_test(1, "reset and idle", errors_before);

		errors_before = error_count;
		do_access(16'h2436); // tag 12 set 3, word 3
		check_bit("cold miss predicted", 1'b1, last_was_miss);
		finish_test(2, "cold miss fill", errors_before);

		errors_before = error_count;
		for (int k = 0; k < block_words; k++) begin
			do_access(16'h2430 + 16'(2 * k));
			check_bit("block hit", 1'b0, last_was_miss);
		end
		finish_test(3, "reread filled block", errors_before);

		errors_before = error_count;
		do_access(16'h2440); // neighbor set 4 with the same tag
		do_access(16'h6A30); // set 3 with tag 35 evicts the first block
		check_bit("conflict refill", 1'b1, last_was_miss);
		do_access(16'h2432);
		check_bit("evicted block misses", 1'b1, last_was_miss);
		do_access(16'h244A);
		check_bit("neighbor still hits", 1'b0, last_was_miss);
		finish_test(4, "index conflict", errors_before);

		errors_before = error_count;
		for (int i = 0; i < random_accesses; i++) begin
			rng_state = xorshift16(rng_state);
			// four tags over eight sets, so hits and conflicts both show up
			r_addr = {tag_pool[rng_state[1:0]], 2'b00, rng_state[4:2], rng_state[11:8]};
			do_access(r_addr);
		end
		finish_test(5, "random addresses", errors_before);

		errors_before = error_count;
		do_access(16'hFC5E); // tag 7e is outside the random pool
		check_bit("held miss predicted", 1'b1, last_was_miss);
		repeat (4) begin
			@(negedge clk);
			check_bit("cpu_resp.rd_valid", 1'b1, cpu_resp.rd_valid);
			check_bit("mem_req.read", 1'b0, mem_req.read);
		end
		@(posedge clk);
		#(drive_delay);
		cpu_req.req = 1'b0;
		check_idle();
		finish_test(6, "held request", errors_before);

		check_number("total mem_read strobes", miss_count * block_words, total_reads);
		$display("tests 6, failed %0d, checks %0d, errors %0d", failed_tests, check_count,
			error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cache_fill.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_fill_fsm.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache_top.sv
bench/mem_model.sv
bench/tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cache fill testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=tb_cache_sim
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cache -f cache_fill.f \
	--Mdir "$build_dir" -o "$sim_exe"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$log_file"; then
	exit 0
fi
echo "pass line not found in $log_file"
exit 1

// File: verilog/cache_data_array.sv
`default_nettype none

`include "cache_fill_config.svh"

module cache_data_array (
	input wire logic clk,
	input cache_pkg::fill_wr_t fill_wr, // one word per strobe during a fill
	input wire logic [`CACHE_INDEX_W-1:0] read_index,
	input wire logic [`CACHE_OFFSET_W-1:0] read_offset, // byte offset, bit 0 ignored
	output logic [`CACHE_WORD_W-1:0] rdata
);

	// word select is the byte offset without its low bit
	localparam int word_sel_w = `CACHE_OFFSET_W - 1;

	// ******************************
	// word storage
	// ******************************

	logic [`CACHE_WORD_W-1:0] words [`CACHE_SETS][`CACHE_BLOCK_WORDS];

	logic [word_sel_w-1:0] wr_word;
	logic [word_sel_w-1:0] rd_word;

	assign wr_word = fill_wr.offset[`CACHE_OFFSET_W-1:1];
	assign rd_word = read_offset[`CACHE_OFFSET_W-1:1];

	// contents are guarded by the valid bits in the tag array
	always_ff @(posedge clk) begin
		if (fill_wr.write_data_array)
			words[fill_wr.index][wr_word] <= fill_wr.data;
	end

	// combinational read so a hit returns data in the request cycle
	assign rdata = words[read_index][rd_word];

endmodule

`default_nettype wire

// File: verilog/cache_fill_config.svh
`ifndef CACHE_FILL_CONFIG_SVH
`define CACHE_FILL_CONFIG_SVH

// ******************************
// cache geometry
// ******************************

// byte address and word width seen by the processor
`define CACHE_ADDR_W 16
`define CACHE_WORD_W 16

// 16 byte blocks, 32 direct mapped sets, the rest of the address is tag
`define CACHE_OFFSET_W 4
`define CACHE_INDEX_W 5
`define CACHE_TAG_W 7

`define CACHE_SETS 32
`define CACHE_BLOCK_WORDS 8 // 16 bytes of 2 byte words

`endif

// File: verilog/cache_fill_fsm.sv
`default_nettype none

`include "cache_fill_config.svh"

module cache_fill_fsm (
	input wire logic clk,
	input wire logic reset,
	input wire logic miss_detected, // from the tag compare, request misses this cycle
	input cache_pkg::cache_addr_t miss_addr,
	input cache_pkg::mem_resp_t mem_resp,
	output cache_pkg::mem_req_t mem_req,
	output cache_pkg::fill_wr_t fill_wr,
	output logic write_tag_array, // one cycle, after the last word is in the data array
	output logic [`CACHE_INDEX_W-1:0] tag_index,
	output logic [`CACHE_TAG_W-1:0] tag_value,
	output logic fsm_busy // doubles as the processor stall while a block is filled
);

	// byte offset of the last word in a block
	localparam logic [`CACHE_OFFSET_W-1:0] last_offset =
		`CACHE_OFFSET_W'(2 * (`CACHE_BLOCK_WORDS - 1));

	logic busy_q;
	logic busy_d;
	cache_pkg::cache_addr_t base_q; // block base, offset field kept at zero
	logic [`CACHE_OFFSET_W-1:0] rd_offset_q; // next word to request from memory
	logic [`CACHE_OFFSET_W-1:0] wr_offset_q; // next word slot to fill
	logic read_done_q; // all 8 reads issued
	logic fill_done_q; // all 8 words written, tag write this cycle
	logic reading;
	logic writing;

	// busy holds until fill_done, so the tag write still sees busy high
	assign busy_d = busy_q ? ~fill_done_q : miss_detected;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= busy_d;
		end
	end

	// latch the block base on the first miss cycle, a miss while busy is ignored
	always_ff @(posedge clk) begin
		if (~busy_q & miss_detected) begin
			base_q.fields.tag <= miss_addr.fields.tag;
			base_q.fields.index <= miss_addr.fields.index;
			base_q.fields.offset <= '0; // block aligned
		end
	end

	// ******************************
	// read side, one request per cycle
	// ******************************

	assign reading = busy_q & ~read_done_q;

	always_ff @(posedge clk) begin
		if (reset | fill_done_q) begin
			rd_offset_q <= '0; // cleared again once the block is complete
			read_done_q <= 1'b0;
		end else if (reading) begin
			rd_offset_q <= rd_offset_q + `CACHE_OFFSET_W'(2); // word step
			if (rd_offset_q == last_offset)
				read_done_q <= 1'b1; // last read goes out this cycle
		end
	end

	// ******************************
	// write side, follows memory_data_valid
	// ******************************

	assign writing = busy_q & mem_resp.valid; // stray data while idle is dropped

	always_ff @(posedge clk) begin
		if (reset | fill_done_q) begin
			wr_offset_q <= '0;
			fill_done_q <= 1'b0;
		end else if (writing) begin
			wr_offset_q <= wr_offset_q + `CACHE_OFFSET_W'(2);
			if (wr_offset_q == last_offset)
				fill_done_q <= 1'b1;
		end
	end

	always_comb begin
		mem_req.read = reading;
		mem_req.addr = base_q.raw + `CACHE_ADDR_W'(rd_offset_q); // base plus byte offset
		fill_wr.write_data_array = writing;
		fill_wr.index = base_q.fields.index;
		fill_wr.offset = wr_offset_q;
		fill_wr.data = mem_resp.data; // returning word goes straight to the array
	end

	assign write_tag_array = busy_q & fill_done_q;
	assign tag_index = base_q.fields.index;
	assign tag_value = base_q.fields.tag;
	assign fsm_busy = busy_q;

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

`include "cache_fill_config.svh"

package cache_pkg;

	// ******************************
	// address views
	// ******************************

	// field split used by lookup and by the fill sequencer
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_OFFSET_W-1:0] offset; // byte offset, bit 0 always ignored
	} addr_fields_t;

	// same 16 bits read either raw (ports, memory) or split into fields
	typedef union packed {
		logic [`CACHE_ADDR_W-1:0] raw;
		addr_fields_t fields;
	} cache_addr_t;

	// ******************************
	// port bundles
	// ******************************

	typedef struct packed {
		logic req; // held high by the processor while stall is high
		cache_addr_t addr;
	} cpu_req_t;

	typedef struct packed {
		logic rd_valid; // hit with no fill in progress
		logic stall; // fill in progress or current request misses
		logic [`CACHE_WORD_W-1:0] rdata;
	} cpu_resp_t;

	typedef struct packed {
		logic read; // one cycle strobe per word
		logic [`CACHE_ADDR_W-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic valid; // one cycle strobe per returning word
		logic [`CACHE_WORD_W-1:0] data;
	} mem_resp_t;

	// fill write from the sequencer into the data array
	typedef struct packed {
		logic write_data_array;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_OFFSET_W-1:0] offset;
		logic [`CACHE_WORD_W-1:0] data;
	} fill_wr_t;

endpackage

`default_nettype wire

// File: verilog/cache_tag_array.sv
`default_nettype none

`include "cache_fill_config.svh"

module cache_tag_array (
	input wire logic clk,
	input wire logic reset,
	input cache_pkg::cache_addr_t lookup_addr, // current processor address
	input wire logic lookup_req,
	input wire logic write_tag_array, // end of fill, install tag and set valid
	input wire logic [`CACHE_INDEX_W-1:0] tag_index,
	input wire logic [`CACHE_TAG_W-1:0] tag_value,
	output logic hit,
	output logic miss_detected
);

	// ******************************
	// storage
	// ******************************

	logic [`CACHE_TAG_W-1:0] tags [`CACHE_SETS];
	logic [`CACHE_SETS-1:0] valid;

	logic [`CACHE_TAG_W-1:0] stored_tag;
	logic stored_valid;

	// tags only mean something once their valid bit is set
	always_ff @(posedge clk) begin
		if (write_tag_array)
			tags[tag_index] <= tag_value;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0; // every set starts empty
		end else if (write_tag_array) begin
			valid[tag_index] <= 1'b1;
		end
	end

	// ******************************
	// lookup
	// ******************************

	// entry for the index field of the request, read combinationally
	assign stored_tag = tags[lookup_addr.fields.index];
	assign stored_valid = valid[lookup_addr.fields.index];

	always_comb begin
		hit = lookup_req & stored_valid & (stored_tag == lookup_addr.fields.tag);
		miss_detected = lookup_req & ~hit; // the fill sequencer ignores this while busy
	end

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`default_nettype none

`include "cache_fill_config.svh"

module cache_top (
	input wire logic clk,
	input wire logic reset,
	input cache_pkg::cpu_req_t cpu_req, // held by the processor while stalled
	output cache_pkg::cpu_resp_t cpu_resp,
	output cache_pkg::mem_req_t mem_req, // one read strobe per word during a fill
	input cache_pkg::mem_resp_t mem_resp
);

	logic hit;
	logic miss_detected;
	logic fsm_busy;
	logic write_tag_array;
	logic [`CACHE_INDEX_W-1:0] tag_index;
	logic [`CACHE_TAG_W-1:0] tag_value;
	logic [`CACHE_WORD_W-1:0] rdata;
	cache_pkg::fill_wr_t fill_wr;

	// ******************************
	// lookup and fill blocks
	// ******************************

	cache_tag_array tag_array_i (
		.clk(clk),
		.reset(reset),
		.lookup_addr(cpu_req.addr),
		.lookup_req(cpu_req.req),
		.write_tag_array(write_tag_array),
		.tag_index(tag_index),
		.tag_value(tag_value),
		.hit(hit),
		.miss_detected(miss_detected)
	);

	// the missing address is the request address itself
	cache_fill_fsm fill_fsm_i (
		.clk(clk),
		.reset(reset),
		.miss_detected(miss_detected),
		.miss_addr(cpu_req.addr),
		.mem_resp(mem_resp),
		.mem_req(mem_req),
		.fill_wr(fill_wr),
		.write_tag_array(write_tag_array),
		.tag_index(tag_index),
		.tag_value(tag_value),
		.fsm_busy(fsm_busy)
	);

	cache_data_array data_array_i (
		.clk(clk),
		.fill_wr(fill_wr),
		.read_index(cpu_req.addr.fields.index),
		.read_offset(cpu_req.addr.fields.offset),
		.rdata(rdata)
	);

	// ******************************
	// processor response
	// ******************************

	always_comb begin
		cpu_resp.stall = fsm_busy | miss_detected; // covers the miss cycle before busy rises
		cpu_resp.rd_valid = hit & ~fsm_busy; // never together with stall
		cpu_resp.rdata = rdata;
	end

endmodule

`default_nettype wire
